//--- bench/lsu_mem_model.sv
// 2 KiB of zeroed byte storage, addresses wrap; load data is read when the request is taken
`timescale 1ns/1ns
`default_nettype none

module lsu_mem_model import lsu_pkg::*; #(
    parameter int seed_init = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_req_valid,
    output logic     mem_req_ready,
    input  mem_req_t mem_req,
    output logic     mem_rsp_valid,
    input  logic     mem_rsp_ready,
    output mem_rsp_t mem_rsp
);

    localparam int mem_size = 2048;

    logic [7:0] mem_bytes [mem_size];
    mem_rsp_t   rsp_q [$];
    int         due_q [$];
    int         cycle = 0;
    integer     seed = seed_init;

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        for (int a = 0; a < mem_size; a++) begin
            mem_bytes[a] = 8'h00;
        end
    end

    always @(posedge clk) begin
        mem_rsp_t rd_data;
        int       a;

        if (reset) begin
            rsp_q.delete();
            due_q.delete();
        end else begin
            cycle++;
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                rd_data = '0;
                for (int i = 0; i < num_lanes; i++) begin
                    a = (mem_req.addr[i] % (mem_size / word_bytes)) * word_bytes;
                    for (int b = 0; b < word_bytes; b++) begin
                        if (mem_req.rw && mem_req.mask[i] && mem_req.byteen[i][b]) begin
                            mem_bytes[a+b] = mem_req.data[i][8*b +: 8];
                        end
                        rd_data.data[i][8*b +: 8] = mem_bytes[a+b];
                    end
                end
                // responses stay in request order, 1 to 4 cycles late
                if (!mem_req.rw) begin
                    rsp_q.push_back(rd_data);
                    due_q.push_back(cycle + 1 + ($random(seed) & 3));
                end
            end
        end
    end

    always @(negedge clk) begin
        mem_req_ready <= ($random(seed) & 3) != 0;
        if (!reset && rsp_q.size() != 0 && due_q[0] <= cycle) begin
            mem_rsp_valid <= 1'b1;
            mem_rsp       <= rsp_q[0];
        end else begin
            mem_rsp_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- bench/lsu_tb.sv
// run from the project root; expected data for lanes off in tmask must be zero in the data file
`timescale 1ns/1ns
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int rand_seed       = 71836;
    localparam int timeout_cycles  = 500;
    localparam int fields_per_line = 17;
    localparam int max_lines       = 32;

    logic     clk;
    logic     reset;
    logic     in_valid;
    logic     in_ready;
    lsu_req_t in_req;
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_req_t mem_req;
    logic     mem_rsp_valid;
    logic     mem_rsp_ready;
    mem_rsp_t mem_rsp;
    logic     commit_valid;
    logic     commit_ready;
    commit_t  commit;

    logic [31:0] tdata [max_lines*fields_per_line];
    commit_t     ld_exp_q [$];
    commit_t     st_exp_q [$];
    // loads ahead of a fence, -1 for a store
    int          st_loads_q [$];
    int          n_lines;
    int          loads_done;
    integer      seed = rand_seed;

    lsu_top dut_i (.*);

    lsu_mem_model #(.seed_init(rand_seed)) mem_model_i (.*);

    always #10 clk = ~clk;

    always @(negedge clk) begin
        commit_ready <= ($random(seed) & 3) != 0;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic lsu_req_t line_req(input int k);
        lsu_req_t r;
        int       b;

        b       = k * fields_per_line;
        r.op    = lsu_op_e'(tdata[b][3:0]);
        r.wid   = tdata[b+1][wid_bits-1:0];
        r.tmask = tdata[b+2][num_lanes-1:0];
        r.rd    = tdata[b+3][reg_bits-1:0];
        r.imm   = tdata[b+4];
        for (int i = 0; i < num_lanes; i++) begin
            r.base[i] = tdata[b+5+i];
            r.data[i] = tdata[b+9+i];
        end
        return r;
    endfunction

    // loads write back rd, stores and fences commit with rd zero
    function automatic commit_t line_commit(input int k);
        lsu_req_t r;
        commit_t  c;

        r       = line_req(k);
        c.wid   = r.wid;
        c.tmask = r.tmask;
        case (r.op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu: c.wb = 1'b1;
            default:                             c.wb = 1'b0;
        endcase
        c.rd = c.wb ? r.rd : '0;
        for (int i = 0; i < num_lanes; i++) begin
            c.data[i] = tdata[k*fields_per_line+13+i];
        end
        return c;
    endfunction

    task automatic check_commit(input commit_t got);
        commit_t exp;
        int      loads_before;

        if (got.wb ? ld_exp_q.size() == 0 : st_exp_q.size() == 0) begin
            fail_run($sformatf("commit at %0t ns has no instruction left to match it", $time));
        end
        if (got.wb) begin
            exp = ld_exp_q.pop_front();
            loads_done++;
        end else begin
            exp          = st_exp_q.pop_front();
            loads_before = st_loads_q.pop_front();
            if (loads_before >= 0) begin
                check_value(loads_done, loads_before, "load commits ahead of fence");
            end
        end
        check_value(got.wid, exp.wid, "commit wid");
        check_value(got.tmask, exp.tmask, "commit tmask");
        check_value(got.rd, exp.rd, "commit rd");
        for (int i = 0; i < num_lanes; i++) begin
            check_value(got.data[i], exp.data[i], $sformatf("commit data lane %0d", i));
        end
    endtask

    always @(posedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            check_commit(commit);
        end
    end

    initial begin
        int       k;
        int       waited;
        int       loads_seen;
        logic     accepted;
        lsu_req_t req;
        commit_t  exp;

        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_req       = '0;
        commit_ready = 1'b0;
        loads_done   = 0;
        loads_seen   = 0;
        n_lines      = 0;

        $readmemh("bench/lsu_testdata.txt", tdata);
        while (n_lines < max_lines && !$isunknown(tdata[n_lines*fields_per_line])) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            fail_run("no instructions were read from the test data file");
        end
        for (k = 0; k < n_lines; k++) begin
            req = line_req(k);
            exp = line_commit(k);
            if (exp.wb) begin
                ld_exp_q.push_back(exp);
                loads_seen++;
            end else begin
                st_exp_q.push_back(exp);
                st_loads_q.push_back(req.op == op_fence ? loads_seen : -1);
            end
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (k = 0; k < n_lines; k++) begin
            in_valid = 1'b1;
            in_req   = line_req(k);
            exp      = line_commit(k);
            // stores and fences carry a nonzero rd that must not reach the commit
            if (!exp.wb) begin
                in_req.rd = '1;
            end
            waited   = 0;
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                accepted = in_ready;
                waited++;
                if (!accepted && waited >= timeout_cycles) begin
                    fail_run($sformatf("the unit stalled: instruction %0d was never accepted", k));
                end
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_req   = '0;

        waited = 0;
        while ((ld_exp_q.size() != 0 || st_exp_q.size() != 0) && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        // a few idle cycles to catch stray commits
        repeat (4) @(negedge clk);

        if (ld_exp_q.size() == 0 && st_exp_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("the unit stalled with %0d load and %0d store commits outstanding",
                     ld_exp_q.size(), st_exp_q.size());
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- bench/lsu_testdata.txt
// op wid tmask rd imm | base lane0..3 | store data lane0..3 | expected commit data lane0..3
// ops: 0 lb 1 lh 2 lw 3 lbu 4 lhu 5 sb 6 sh 7 sw 8 fence; hex fields, lane 0 first
7 0 f 0 0  100 104 108 10c  11111111 22222222 33333333 44444444  0 0 0 0
7 1 5 0 10  100 104 108 10c  aaaaaaaa bbbbbbbb cccccccc dddddddd  0 0 0 0
2 0 f 3 0  100 104 108 10c  0 0 0 0  11111111 22222222 33333333 44444444
2 1 f 4 10  100 104 108 10c  0 0 0 0  aaaaaaaa 0 cccccccc 0
2 2 6 5 0  100 104 108 10c  0 0 0 0  0 22222222 33333333 0
7 0 f 0 0  200 204 208 20c  0 11223344 55667788 99aabbcc  0 0 0 0
5 0 f 0 0  201 206 20b 20c  5a5a5aef 5a5a5acd 5a5a5aab 5a5a5a99  0 0 0 0
6 1 f 0 0  202 204 20a 20e  7777beef 7777cafe 77771234 7777f00d  0 0 0 0
2 2 f 6 0  200 204 208 20c  0 0 0 0  beefef00 11cdcafe 12347788 f00dbb99
7 3 f 0 0  300 304 308 30c  80ff7f81 7fff8001 c3a5e17e 01fe807f  0 0 0 0
0 3 f 7 0  300 305 30a 30f  0 0 0 0  ffffff81 ffffff80 ffffffa5 00000001
3 3 f 8 0  301 302 30b 30c  0 0 0 0  0000007f 000000ff 000000c3 0000007f
1 0 f 9 0  302 306 30a 30c  0 0 0 0  ffff80ff 00007fff ffffc3a5 ffff807f
4 1 f a 0  302 304 30a 30e  0 0 0 0  000080ff 00008001 0000c3a5 000001fe
0 2 9 b 0  303 307 30b 30d  0 0 0 0  ffffff80 0 0 ffffff80
2 0 f c 0  100 104 108 10c  0 0 0 0  11111111 22222222 33333333 44444444
3 1 f d 0  200 201 202 203  0 0 0 0  0 000000ef 000000ef 000000be
4 2 f e 0  204 206 208 20a  0 0 0 0  0000cafe 000011cd 00007788 00001234
2 3 f f 0  300 304 308 30c  0 0 0 0  80ff7f81 7fff8001 c3a5e17e 01fe807f
1 0 f 10 0  110 11a 118 11e  0 0 0 0  ffffaaaa ffffcccc ffffcccc 0
8 1 f 0 0  0 0 0 0  0 0 0 0  0 0 0 0
7 2 f 0 4  400 404 408 40c  01020304 05060708 090a0b0c 0d0e0f10  0 0 0 0
2 3 f 11 0  404 408 40c 410  0 0 0 0  01020304 05060708 090a0b0c 0d0e0f10
8 0 3 0 0  0 0 0 0  0 0 0 0  0 0 0 0

//--- hw/lsu_addr_gen.sv
// aligned accesses only; a misaligned half or word is not detected
`timescale 1ns/1ns
`default_nettype none

module lsu_addr_gen import lsu_pkg::*; (
    input  lsu_req_t in_req,
    input  logic     is_store,
    output mem_req_t mem_req,
    output logic [num_lanes-1:0][align_bits-1:0] offsets
);

    logic [num_lanes-1:0][xlen-1:0] full_addr;

    always_comb begin
        mem_req.rw   = is_store;
        mem_req.mask = in_req.tmask;
        for (int i = 0; i < num_lanes; i++) begin
            full_addr[i]    = in_req.base[i] + in_req.imm;
            offsets[i]      = full_addr[i][align_bits-1:0];
            mem_req.addr[i] = full_addr[i][xlen-1:align_bits];

            case (in_req.op)
                op_lb, op_lbu, op_sb: begin
                    mem_req.byteen[i] = word_bytes'(1) << offsets[i];
                end
                // half keeps its aligned pair
                op_lh, op_lhu, op_sh: begin
                    mem_req.byteen[i] = word_bytes'(3) << {offsets[i][1], 1'b0};
                end
                default: begin
                    mem_req.byteen[i] = '1;
                end
            endcase

            // store data moved into byte position
            mem_req.data[i] = in_req.data[i] << {offsets[i], 3'b000};
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_commit_arb.sv
// one cycle through the output register; the ready inputs do not depend on their own valid
`timescale 1ns/1ns
`default_nettype none

module lsu_commit_arb import lsu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    ld_valid,
    output logic    ld_ready,
    input  commit_t ld_commit,
    input  logic    st_valid,
    output logic    st_ready,
    input  commit_t st_commit,
    output logic    commit_valid,
    input  logic    commit_ready,
    output commit_t commit
);

    logic prio_ld;
    logic out_free;
    logic ld_fire;
    logic st_fire;

    assign out_free = !commit_valid || commit_ready;

    // loser of a tie gets priority next
    assign ld_ready = out_free && (prio_ld || !st_valid);
    assign st_ready = out_free && (!prio_ld || !ld_valid);
    assign ld_fire  = ld_valid && ld_ready;
    assign st_fire  = st_valid && st_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            prio_ld      <= 1'b1;
        end else begin
            if (out_free) begin
                commit_valid <= ld_fire || st_fire;
            end
            if (ld_fire) begin
                prio_ld <= 1'b0;
            end else if (st_fire) begin
                prio_ld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_fire) begin
            commit <= ld_commit;
        end else if (st_fire) begin
            commit <= st_commit;
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_ctrl.sv
// stores commit when written; unknown opcodes are consumed without effect
`timescale 1ns/1ns
`default_nettype none

module lsu_ctrl import lsu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_ready,
    input  lsu_req_t   in_req,
    input  logic [num_lanes-1:0][align_bits-1:0] offsets,
    output logic       is_store,
    input  logic       mem_req_ready,
    output logic       mem_req_valid,
    input  logic       q_empty,
    input  logic       q_full,
    output logic       q_push,
    output load_meta_t q_push_meta,
    output logic       st_valid,
    input  logic       st_ready,
    output commit_t    st_commit
);

    logic is_load;
    logic is_fence;
    logic st_cond;
    logic mem_fire;
    logic in_fire;
    // store request raised but not yet taken, and store already written
    logic req_held;
    logic mem_sent;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_fence = 1'b0;
        case (in_req.op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu: is_load = 1'b1;
            op_sb, op_sh, op_sw:                 is_store = 1'b1;
            op_fence:                            is_fence = 1'b1;
            default:;
        endcase
    end

    // fence waits here for the load queue to drain
    assign st_cond = is_store ? (mem_sent || mem_req_ready) : q_empty;

    // once raised, a store request stays up even if the commit side stalls
    assign mem_req_valid = in_valid && !mem_sent
                         && ((is_load && !q_full) || (is_store && (st_ready || req_held)));
    assign mem_fire = mem_req_valid && mem_req_ready;

    assign st_valid = in_valid && (is_store || is_fence) && st_cond;

    always_comb begin
        if (is_load) begin
            in_ready = mem_req_ready && !q_full;
        end else if (is_store || is_fence) begin
            in_ready = st_ready && st_cond;
        end else begin
            in_ready = 1'b1;
        end
    end

    assign in_fire = in_valid && in_ready;
    assign q_push  = mem_fire && is_load;

    assign q_push_meta.op     = in_req.op;
    assign q_push_meta.wid    = in_req.wid;
    assign q_push_meta.tmask  = in_req.tmask;
    assign q_push_meta.rd     = in_req.rd;
    assign q_push_meta.offset = offsets;

    assign st_commit.wid   = in_req.wid;
    assign st_commit.tmask = in_req.tmask;
    assign st_commit.rd    = '0;
    assign st_commit.wb    = 1'b0;
    assign st_commit.data  = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_held <= 1'b0;
            mem_sent <= 1'b0;
        end else if (in_fire) begin
            req_held <= 1'b0;
            mem_sent <= 1'b0;
        end else begin
            req_held <= mem_req_valid && !mem_req_ready;
            if (mem_fire) begin
                mem_sent <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_load_format.sv
// inactive lanes return zero data
`timescale 1ns/1ns
`default_nettype none

module lsu_load_format import lsu_pkg::*; (
    input  load_meta_t head,
    input  mem_rsp_t   mem_rsp,
    output commit_t    ld_commit
);

    always_comb begin
        logic [15:0] half_sel;
        logic [7:0]  byte_sel;

        ld_commit.wid   = head.wid;
        ld_commit.tmask = head.tmask;
        ld_commit.rd    = head.rd;
        ld_commit.wb    = 1'b1;
        for (int i = 0; i < num_lanes; i++) begin
            half_sel = head.offset[i][1] ? mem_rsp.data[i][31:16] : mem_rsp.data[i][15:0];
            byte_sel = head.offset[i][0] ? half_sel[15:8] : half_sel[7:0];
            case (head.op)
                op_lb:   ld_commit.data[i] = {{(xlen-8){byte_sel[7]}}, byte_sel};
                op_lh:   ld_commit.data[i] = {{(xlen-16){half_sel[15]}}, half_sel};
                op_lbu:  ld_commit.data[i] = {{(xlen-8){1'b0}}, byte_sel};
                op_lhu:  ld_commit.data[i] = {{(xlen-16){1'b0}}, half_sel};
                default: ld_commit.data[i] = mem_rsp.data[i];
            endcase
            if (!head.tmask[i]) begin
                ld_commit.data[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_load_queue.sv
// push when full and pop when empty are ignored
`timescale 1ns/1ns
`default_nettype none

module lsu_load_queue import lsu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  load_meta_t push_meta,
    input  logic       pop,
    output load_meta_t head,
    output logic       empty,
    output logic       full
);

    localparam int ptr_bits = $clog2(lsuq_size);
    localparam int cnt_bits = $clog2(lsuq_size + 1);

    load_meta_t mem [lsuq_size];
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] wr_ptr;
    logic [cnt_bits-1:0] count;
    logic do_push;
    logic do_pop;

    assign empty   = (count == '0);
    assign full    = (count == cnt_bits'(lsuq_size));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_bits'(lsuq_size - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_bits'(lsuq_size - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_bits'(do_push) - cnt_bits'(do_pop);
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
// aligned accesses only; memory must answer loads in request order
`default_nettype none

package lsu_pkg;

    localparam int num_lanes      = 4;
    localparam int xlen           = 32;
    localparam int word_bytes     = xlen / 8;
    localparam int align_bits     = $clog2(word_bytes);
    localparam int word_addr_bits = xlen - align_bits;
    localparam int num_warps      = 4;
    localparam int wid_bits       = $clog2(num_warps);
    localparam int reg_bits       = 5;
    localparam int lsuq_size      = 4;

    typedef enum logic [3:0] {
        op_lb    = 4'h0,
        op_lh    = 4'h1,
        op_lw    = 4'h2,
        op_lbu   = 4'h3,
        op_lhu   = 4'h4,
        op_sb    = 4'h5,
        op_sh    = 4'h6,
        op_sw    = 4'h7,
        op_fence = 4'h8
    } lsu_op_e;

    typedef struct packed {
        lsu_op_e                        op;
        logic [wid_bits-1:0]            wid;
        logic [num_lanes-1:0]           tmask;
        logic [reg_bits-1:0]            rd;
        logic [xlen-1:0]                imm;
        logic [num_lanes-1:0][xlen-1:0] base;
        logic [num_lanes-1:0][xlen-1:0] data;
    } lsu_req_t;

    // rw high for write
    typedef struct packed {
        logic                                     rw;
        logic [num_lanes-1:0]                     mask;
        logic [num_lanes-1:0][word_addr_bits-1:0] addr;
        logic [num_lanes-1:0][word_bytes-1:0]     byteen;
        logic [num_lanes-1:0][xlen-1:0]           data;
    } mem_req_t;

    typedef struct packed {
        logic [num_lanes-1:0][xlen-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        lsu_op_e                              op;
        logic [wid_bits-1:0]                  wid;
        logic [num_lanes-1:0]                 tmask;
        logic [reg_bits-1:0]                  rd;
        logic [num_lanes-1:0][align_bits-1:0] offset;
    } load_meta_t;

    typedef struct packed {
        logic [wid_bits-1:0]            wid;
        logic [num_lanes-1:0]           tmask;
        logic [reg_bits-1:0]            rd;
        logic                           wb;
        logic [num_lanes-1:0][xlen-1:0] data;
    } commit_t;

endpackage

`default_nettype wire

//--- hw/lsu_top.sv
// aligned accesses only; memory answers loads in order, at most lsuq_size loads in flight
`timescale 1ns/1ns
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  lsu_req_t in_req,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    output mem_req_t mem_req,
    input  logic     mem_rsp_valid,
    output logic     mem_rsp_ready,
    input  mem_rsp_t mem_rsp,
    output logic     commit_valid,
    input  logic     commit_ready,
    output commit_t  commit
);

    logic [num_lanes-1:0][align_bits-1:0] offsets;
    logic       is_store;
    logic       q_empty;
    logic       q_full;
    logic       q_push;
    load_meta_t q_push_meta;
    load_meta_t q_head;
    logic       rsp_fire;
    logic       st_valid;
    logic       st_ready;
    commit_t    st_commit;
    commit_t    ld_commit;

    assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

    lsu_ctrl ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_req        (in_req),
        .offsets       (offsets),
        .is_store      (is_store),
        .mem_req_ready (mem_req_ready),
        .mem_req_valid (mem_req_valid),
        .q_empty       (q_empty),
        .q_full        (q_full),
        .q_push        (q_push),
        .q_push_meta   (q_push_meta),
        .st_valid      (st_valid),
        .st_ready      (st_ready),
        .st_commit     (st_commit)
    );

    lsu_addr_gen addr_gen_i (
        .in_req   (in_req),
        .is_store (is_store),
        .mem_req  (mem_req),
        .offsets  (offsets)
    );

    lsu_load_queue load_queue_i (
        .clk       (clk),
        .reset     (reset),
        .push      (q_push),
        .push_meta (q_push_meta),
        .pop       (rsp_fire),
        .head      (q_head),
        .empty     (q_empty),
        .full      (q_full)
    );

    lsu_load_format load_format_i (
        .head      (q_head),
        .mem_rsp   (mem_rsp),
        .ld_commit (ld_commit)
    );

    lsu_commit_arb commit_arb_i (
        .clk          (clk),
        .reset        (reset),
        .ld_valid     (mem_rsp_valid),
        .ld_ready     (mem_rsp_ready),
        .ld_commit    (ld_commit),
        .st_valid     (st_valid),
        .st_ready     (st_ready),
        .st_commit    (st_commit),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

endmodule

`default_nettype wire

//--- sim.f
hw/lsu_pkg.sv
hw/lsu_addr_gen.sv
hw/lsu_ctrl.sv
hw/lsu_load_queue.sv
hw/lsu_load_format.sv
hw/lsu_commit_arb.sv
hw/lsu_top.sv
bench/lsu_mem_model.sv
bench/lsu_tb.sv
